// ==== logic/regfile_pkg.sv ====
// shared widths and counts for the banked register file
// address layout is {row, bank, tile}, tile in the low bits
// sweep state type for the post-reset clear
package regfile_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 6;

  // address bits 1..0
  localparam int TILE_W = 2;
  localparam int NUM_TILES = 4;

  // address bits 5..3, bit 2 is the bank select
  localparam int ROW_W = 3;
  localparam int NUM_ROWS = 8;
  localparam int NUM_BANKS = 2;

  // operand read ports
  localparam int NUM_READ = 2;

  // one clear cycle per row of each bank
  localparam int SWEEP_LEN = NUM_ROWS * NUM_BANKS;

  typedef enum logic {
    SWEEP_CLEAR,
    SWEEP_DONE
  } sweep_state_t;

endpackage

// ==== logic/rf_bank_ram.sv ====
// one bank of NUM_ROWS registers
// two write ports, port 1 applied last so it wins a collision
// operand rows captured under rd_advance, retire row under ret_en
`timescale 1ns/10ps

module rf_bank_ram (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rd_advance,
  input  logic                             ret_en,
  input  logic [regfile_pkg::ROW_W-1:0]    rd0_row,
  input  logic [regfile_pkg::ROW_W-1:0]    rd1_row,
  input  logic [regfile_pkg::ROW_W-1:0]    ret_row,
  input  logic                             wr0_en,
  input  logic [regfile_pkg::ROW_W-1:0]    wr0_row,
  input  logic [regfile_pkg::DATA_W-1:0]   wr0_data,
  input  logic                             wr1_en,
  input  logic [regfile_pkg::ROW_W-1:0]    wr1_row,
  input  logic [regfile_pkg::DATA_W-1:0]   wr1_data,
  output logic [regfile_pkg::DATA_W-1:0]   rd0_data,
  output logic [regfile_pkg::DATA_W-1:0]   rd1_data,
  output logic [regfile_pkg::DATA_W-1:0]   ret_data
);

  logic [regfile_pkg::DATA_W-1:0] mem [regfile_pkg::NUM_ROWS];

  logic [regfile_pkg::ROW_W-1:0] rd0_row_q;
  logic [regfile_pkg::ROW_W-1:0] rd1_row_q;
  logic [regfile_pkg::ROW_W-1:0] ret_row_q;

  // captured rows hold while the read side is stalled
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd0_row_q <= '0;
      rd1_row_q <= '0;
      ret_row_q <= '0;
    end
    else
    begin
      if (rd_advance)
      begin
        rd0_row_q <= rd0_row;
        rd1_row_q <= rd1_row;
      end
      if (ret_en)
      begin
        ret_row_q <= ret_row;
      end
    end
  end

  // later assignment takes effect, so port 1 overrides port 0
  always_ff @(posedge clk)
  begin
    if (wr0_en)
    begin
      mem[wr0_row] <= wr0_data;
    end
    if (wr1_en)
    begin
      mem[wr1_row] <= wr1_data;
    end
  end

  // live read of the captured row, a write shows up right after its edge
  assign rd0_data = mem[rd0_row_q];
  assign rd1_data = mem[rd1_row_q];
  assign ret_data = mem[ret_row_q];

endmodule

// ==== logic/rf_tile.sv ====
// one register tile made of two banks
// tile match and bank decode for the write ports, sweep override on port 0
// registered per-port bank enables gate the operand outputs to zero
`timescale 1ns/10ps

module rf_tile (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [regfile_pkg::TILE_W-1:0]   tile_id,
  input  logic                             rd_advance,
  input  logic                             ret_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   rd0_addr,
  input  logic [regfile_pkg::ADDR_W-1:0]   rd1_addr,
  input  logic                             rd0_const_en,
  input  logic                             rd1_const_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   ret_addr,
  input  logic                             wr0_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   wr0_addr,
  input  logic [regfile_pkg::DATA_W-1:0]   wr0_data,
  input  logic                             wr1_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   wr1_addr,
  input  logic [regfile_pkg::DATA_W-1:0]   wr1_data,
  input  logic                             clear_en,
  input  logic [regfile_pkg::ROW_W-1:0]    clear_row,
  input  logic                             clear_bank,
  output logic [regfile_pkg::DATA_W-1:0]   tile_rd0_data,
  output logic [regfile_pkg::DATA_W-1:0]   tile_rd1_data,
  output logic [regfile_pkg::DATA_W-1:0]   tile_ret_data
);

  logic rd0_match;
  logic rd1_match;
  logic wr0_match;
  logic wr1_match;

  logic [regfile_pkg::NUM_BANKS-1:0] wr0_bank_en;
  logic [regfile_pkg::NUM_BANKS-1:0] wr1_bank_en;
  logic [regfile_pkg::NUM_BANKS-1:0] rd0_bank_en_q;
  logic [regfile_pkg::NUM_BANKS-1:0] rd1_bank_en_q;
  logic                              ret_bank_q;

  logic [regfile_pkg::ROW_W-1:0]  wr0_row_mux;
  logic [regfile_pkg::DATA_W-1:0] wr0_data_mux;

  logic [regfile_pkg::DATA_W-1:0] rd0_bank_data [regfile_pkg::NUM_BANKS];
  logic [regfile_pkg::DATA_W-1:0] rd1_bank_data [regfile_pkg::NUM_BANKS];
  logic [regfile_pkg::DATA_W-1:0] ret_bank_data [regfile_pkg::NUM_BANKS];

  assign rd0_match = (rd0_addr[regfile_pkg::TILE_W-1:0] == tile_id);
  assign rd1_match = (rd1_addr[regfile_pkg::TILE_W-1:0] == tile_id);
  assign wr0_match = (wr0_addr[regfile_pkg::TILE_W-1:0] == tile_id);
  assign wr1_match = (wr1_addr[regfile_pkg::TILE_W-1:0] == tile_id);

  // sweep takes over write port 0, external writes are masked meanwhile
  assign wr0_row_mux  = clear_en ? clear_row
                                 : wr0_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W];
  assign wr0_data_mux = clear_en ? '0 : wr0_data;

  assign wr0_bank_en[0] = clear_en ? ~clear_bank
                                   : (wr0_en & wr0_match & ~wr0_addr[regfile_pkg::TILE_W]);
  assign wr0_bank_en[1] = clear_en ? clear_bank
                                   : (wr0_en & wr0_match & wr0_addr[regfile_pkg::TILE_W]);
  assign wr1_bank_en[0] = ~clear_en & wr1_en & wr1_match & ~wr1_addr[regfile_pkg::TILE_W];
  assign wr1_bank_en[1] = ~clear_en & wr1_en & wr1_match & wr1_addr[regfile_pkg::TILE_W];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd0_bank_en_q <= '0;
      rd1_bank_en_q <= '0;
      ret_bank_q    <= 1'b0;
    end
    else
    begin
      if (rd_advance)
      begin
        // a constant read leaves every bank output off
        rd0_bank_en_q[0] <= rd0_match & ~rd0_const_en & ~rd0_addr[regfile_pkg::TILE_W];
        rd0_bank_en_q[1] <= rd0_match & ~rd0_const_en & rd0_addr[regfile_pkg::TILE_W];
        rd1_bank_en_q[0] <= rd1_match & ~rd1_const_en & ~rd1_addr[regfile_pkg::TILE_W];
        rd1_bank_en_q[1] <= rd1_match & ~rd1_const_en & rd1_addr[regfile_pkg::TILE_W];
      end
      if (ret_en)
      begin
        ret_bank_q <= ret_addr[regfile_pkg::TILE_W];
      end
    end
  end

  // bank A holds bank bit 0, bank B bank bit 1
  rf_bank_ram u_bank_a (
    .clk        (clk),
    .rst        (rst),
    .rd_advance (rd_advance),
    .ret_en     (ret_en),
    .rd0_row    (rd0_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .rd1_row    (rd1_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .ret_row    (ret_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .wr0_en     (wr0_bank_en[0]),
    .wr0_row    (wr0_row_mux),
    .wr0_data   (wr0_data_mux),
    .wr1_en     (wr1_bank_en[0]),
    .wr1_row    (wr1_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .wr1_data   (wr1_data),
    .rd0_data   (rd0_bank_data[0]),
    .rd1_data   (rd1_bank_data[0]),
    .ret_data   (ret_bank_data[0])
  );

  rf_bank_ram u_bank_b (
    .clk        (clk),
    .rst        (rst),
    .rd_advance (rd_advance),
    .ret_en     (ret_en),
    .rd0_row    (rd0_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .rd1_row    (rd1_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .ret_row    (ret_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .wr0_en     (wr0_bank_en[1]),
    .wr0_row    (wr0_row_mux),
    .wr0_data   (wr0_data_mux),
    .wr1_en     (wr1_bank_en[1]),
    .wr1_row    (wr1_addr[regfile_pkg::ADDR_W-1 -: regfile_pkg::ROW_W]),
    .wr1_data   (wr1_data),
    .rd0_data   (rd0_bank_data[1]),
    .rd1_data   (rd1_bank_data[1]),
    .ret_data   (ret_bank_data[1])
  );

  // at most one enable is set, so the OR acts as a mux
  assign tile_rd0_data = ({regfile_pkg::DATA_W{rd0_bank_en_q[0]}} & rd0_bank_data[0])
                       | ({regfile_pkg::DATA_W{rd0_bank_en_q[1]}} & rd0_bank_data[1]);
  assign tile_rd1_data = ({regfile_pkg::DATA_W{rd1_bank_en_q[0]}} & rd1_bank_data[0])
                       | ({regfile_pkg::DATA_W{rd1_bank_en_q[1]}} & rd1_bank_data[1]);

  assign tile_ret_data = ret_bank_q ? ret_bank_data[1] : ret_bank_data[0];

endmodule

// ==== logic/rf_init_sweep.sv ====
// zero-initialisation sweep run after reset
// steps through every {row, bank} pair, one per cycle
`timescale 1ns/10ps

module rf_init_sweep (
  input  logic                            clk,
  input  logic                            rst,
  output logic                            clear_en,
  output logic [regfile_pkg::ROW_W-1:0]   clear_row,
  output logic                            clear_bank,
  output logic                            init_busy
);

  regfile_pkg::sweep_state_t state;

  // low bit is the bank, upper bits the row
  logic [regfile_pkg::ROW_W:0] sweep_cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= regfile_pkg::SWEEP_CLEAR;
      sweep_cnt <= '0;
    end
    else if (state == regfile_pkg::SWEEP_CLEAR)
    begin
      sweep_cnt <= sweep_cnt + 1'b1;
      // last entry is written on this edge
      if (int'(sweep_cnt) == regfile_pkg::SWEEP_LEN - 1)
      begin
        state <= regfile_pkg::SWEEP_DONE;
      end
    end
  end

  assign clear_en   = (state == regfile_pkg::SWEEP_CLEAR);
  assign init_busy  = (state == regfile_pkg::SWEEP_CLEAR);
  assign clear_bank = sweep_cnt[0];
  assign clear_row  = sweep_cnt[regfile_pkg::ROW_W:1];

endmodule

// ==== logic/rf_read_merge.sv ====
// merges the per-tile read outputs into the external read ports
// constant bypass per operand port, retire tile select
`timescale 1ns/10ps

module rf_read_merge (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 rd_advance,
  input  logic                                                 ret_en,
  input  logic                                                 rd0_const_en,
  input  logic                                                 rd1_const_en,
  input  logic [regfile_pkg::DATA_W-1:0]                       rd0_const,
  input  logic [regfile_pkg::DATA_W-1:0]                       rd1_const,
  input  logic [regfile_pkg::TILE_W-1:0]                       ret_tile,
  input  logic [regfile_pkg::NUM_TILES-1:0][regfile_pkg::DATA_W-1:0] tile_rd0_data,
  input  logic [regfile_pkg::NUM_TILES-1:0][regfile_pkg::DATA_W-1:0] tile_rd1_data,
  input  logic [regfile_pkg::NUM_TILES-1:0][regfile_pkg::DATA_W-1:0] tile_ret_data,
  output logic [regfile_pkg::DATA_W-1:0]                       rd0_data,
  output logic [regfile_pkg::DATA_W-1:0]                       rd1_data,
  output logic [regfile_pkg::DATA_W-1:0]                       ret_data
);

  logic [regfile_pkg::NUM_READ-1:0]                          const_en_q;
  logic [regfile_pkg::NUM_READ-1:0][regfile_pkg::DATA_W-1:0] const_q;
  logic [regfile_pkg::TILE_W-1:0]                            ret_tile_q;

  logic [regfile_pkg::DATA_W-1:0] rd0_or;
  logic [regfile_pkg::DATA_W-1:0] rd1_or;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      const_en_q <= '0;
      const_q    <= '0;
      ret_tile_q <= '0;
    end
    else
    begin
      if (rd_advance)
      begin
        const_en_q <= {rd1_const_en, rd0_const_en};
        const_q[0] <= rd0_const;
        const_q[1] <= rd1_const;
      end
      if (ret_en)
      begin
        ret_tile_q <= ret_tile;
      end
    end
  end

  // unmatched tiles drive zero
  always_comb
  begin
    rd0_or = '0;
    rd1_or = '0;
    for (int t = 0; t < regfile_pkg::NUM_TILES; t++)
    begin
      rd0_or = rd0_or | tile_rd0_data[t];
      rd1_or = rd1_or | tile_rd1_data[t];
    end
  end

  assign rd0_data = const_en_q[0] ? const_q[0] : rd0_or;
  assign rd1_data = const_en_q[1] ? const_q[1] : rd1_or;
  assign ret_data = tile_ret_data[ret_tile_q];

endmodule

// ==== logic/regfile_top.sv ====
// banked register file top level
// init sweep, four tiles of two banks and the read merge
`timescale 1ns/10ps

module regfile_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rd_advance,
  input  logic [regfile_pkg::ADDR_W-1:0]   rd0_addr,
  input  logic [regfile_pkg::ADDR_W-1:0]   rd1_addr,
  input  logic                             rd0_const_en,
  input  logic                             rd1_const_en,
  input  logic [regfile_pkg::DATA_W-1:0]   rd0_const,
  input  logic [regfile_pkg::DATA_W-1:0]   rd1_const,
  input  logic                             ret_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   ret_addr,
  input  logic                             wr0_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   wr0_addr,
  input  logic [regfile_pkg::DATA_W-1:0]   wr0_data,
  input  logic                             wr1_en,
  input  logic [regfile_pkg::ADDR_W-1:0]   wr1_addr,
  input  logic [regfile_pkg::DATA_W-1:0]   wr1_data,
  output logic [regfile_pkg::DATA_W-1:0]   rd0_data,
  output logic [regfile_pkg::DATA_W-1:0]   rd1_data,
  output logic [regfile_pkg::DATA_W-1:0]   ret_data,
  output logic                             init_busy
);

  logic                          clear_en;
  logic [regfile_pkg::ROW_W-1:0] clear_row;
  logic                          clear_bank;

  logic [regfile_pkg::NUM_TILES-1:0][regfile_pkg::DATA_W-1:0] tile_rd0_data;
  logic [regfile_pkg::NUM_TILES-1:0][regfile_pkg::DATA_W-1:0] tile_rd1_data;
  logic [regfile_pkg::NUM_TILES-1:0][regfile_pkg::DATA_W-1:0] tile_ret_data;

  rf_init_sweep u_sweep (
    .clk        (clk),
    .rst        (rst),
    .clear_en   (clear_en),
    .clear_row  (clear_row),
    .clear_bank (clear_bank),
    .init_busy  (init_busy)
  );

  // every tile sees all ports and claims the addresses whose low bits match
  for (genvar t = 0; t < regfile_pkg::NUM_TILES; t++)
  begin : g_tile
    rf_tile u_tile (
      .clk           (clk),
      .rst           (rst),
      .tile_id       ((regfile_pkg::TILE_W)'(t)),
      .rd_advance    (rd_advance),
      .ret_en        (ret_en),
      .rd0_addr      (rd0_addr),
      .rd1_addr      (rd1_addr),
      .rd0_const_en  (rd0_const_en),
      .rd1_const_en  (rd1_const_en),
      .ret_addr      (ret_addr),
      .wr0_en        (wr0_en),
      .wr0_addr      (wr0_addr),
      .wr0_data      (wr0_data),
      .wr1_en        (wr1_en),
      .wr1_addr      (wr1_addr),
      .wr1_data      (wr1_data),
      .clear_en      (clear_en),
      .clear_row     (clear_row),
      .clear_bank    (clear_bank),
      .tile_rd0_data (tile_rd0_data[t]),
      .tile_rd1_data (tile_rd1_data[t]),
      .tile_ret_data (tile_ret_data[t])
    );
  end

  rf_read_merge u_merge (
    .clk           (clk),
    .rst           (rst),
    .rd_advance    (rd_advance),
    .ret_en        (ret_en),
    .rd0_const_en  (rd0_const_en),
    .rd1_const_en  (rd1_const_en),
    .rd0_const     (rd0_const),
    .rd1_const     (rd1_const),
    .ret_tile      (ret_addr[regfile_pkg::TILE_W-1:0]),
    .tile_rd0_data (tile_rd0_data),
    .tile_rd1_data (tile_rd1_data),
    .tile_ret_data (tile_ret_data),
    .rd0_data      (rd0_data),
    .rd1_data      (rd1_data),
    .ret_data      (ret_data)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// clock and reset source for the testbench
// 100 ns period, reset held for the first 10 rising edges
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 10;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // released on a falling edge so the synchronous reset sees a clean level
  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== tb/tb_checker.sv ====
// output checker for the register file testbench
// compares read or retire data against the expected values one falling edge later
// checks that init_busy covers reset and the full zero sweep
// counts the checks made and the errors found
`timescale 1ns/10ps

module tb_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           init_busy,
  input  logic                           exp_valid,
  input  logic                           exp_port,
  input  logic [regfile_pkg::DATA_W-1:0] exp_data0,
  input  logic [regfile_pkg::DATA_W-1:0] exp_data1,
  input  logic [regfile_pkg::DATA_W-1:0] rd0_data,
  input  logic [regfile_pkg::DATA_W-1:0] rd1_data,
  input  logic [regfile_pkg::DATA_W-1:0] ret_data,
  output int                             error_count,
  output int                             check_count
);

  int errors = 0;
  int checks = 0;
  int sweep_edges = 0;
  bit sweep_checked = 1'b0;

  assign error_count = errors;
  assign check_count = checks;

  task automatic compare_word(
    input string                          name,
    input logic [regfile_pkg::DATA_W-1:0] expected,
    input logic [regfile_pkg::DATA_W-1:0] got
  );
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("FAILED %s expected %h got %h at %0t", name, expected, got, $time);
    end
  endtask

  // rising edges seen since reset was released
  always @(posedge clk)
  begin
    if (rst)
    begin
      sweep_edges = 0;
    end
    else if (!sweep_checked)
    begin
      sweep_edges++;
    end
  end

  // init_busy stays high through reset and one clear cycle per row of each bank
  always @(negedge clk)
  begin
    if (!sweep_checked)
    begin
      if (sweep_edges == 0)
      begin
        checks++;
        if (init_busy !== 1'b1)
        begin
          errors++;
          $display("FAILED init_busy expected %h got %h at %0t", 1'b1, init_busy, $time);
        end
      end
      else if (init_busy !== 1'b1)
      begin
        sweep_checked = 1'b1;
        compare_word("init_busy cycles", regfile_pkg::NUM_ROWS * regfile_pkg::NUM_BANKS,
                     sweep_edges);
      end
    end
  end

  // exp_port 0 covers both operand ports, 1 the retire port
  always @(negedge clk)
  begin
    if (exp_valid)
    begin
      if (exp_port)
      begin
        compare_word("ret_data", exp_data0, ret_data);
      end
      else
      begin
        compare_word("rd0_data", exp_data0, rd0_data);
        compare_word("rd1_data", exp_data1, rd1_data);
      end
    end
  end

endmodule

// ==== tb/tb_regfile.sv ====
// testbench top for the banked register file
// reads commands from tb/regfile_input.txt and drives the DUT on falling edges
// expected values go to the checker, which compares on the following falling edge
`timescale 1ns/10ps

module tb_regfile;

  localparam int FIELDS = 7;
  localparam int MAX_CMDS = 64;
  localparam int RESET_TIMEOUT = 40;
  localparam int SWEEP_TIMEOUT = 64;

  logic                           clk;
  logic                           rst;
  logic                           rd_advance;
  logic [regfile_pkg::ADDR_W-1:0] rd0_addr;
  logic [regfile_pkg::ADDR_W-1:0] rd1_addr;
  logic                           rd0_const_en;
  logic                           rd1_const_en;
  logic [regfile_pkg::DATA_W-1:0] rd0_const;
  logic [regfile_pkg::DATA_W-1:0] rd1_const;
  logic                           ret_en;
  logic [regfile_pkg::ADDR_W-1:0] ret_addr;
  logic                           wr0_en;
  logic [regfile_pkg::ADDR_W-1:0] wr0_addr;
  logic [regfile_pkg::DATA_W-1:0] wr0_data;
  logic                           wr1_en;
  logic [regfile_pkg::ADDR_W-1:0] wr1_addr;
  logic [regfile_pkg::DATA_W-1:0] wr1_data;
  logic [regfile_pkg::DATA_W-1:0] rd0_data;
  logic [regfile_pkg::DATA_W-1:0] rd1_data;
  logic [regfile_pkg::DATA_W-1:0] ret_data;
  logic                           init_busy;

  logic                           exp_valid;
  logic                           exp_port;
  logic [regfile_pkg::DATA_W-1:0] exp_data0;
  logic [regfile_pkg::DATA_W-1:0] exp_data1;

  logic [31:0] cmds [MAX_CMDS*FIELDS];
  int          checker_errors;
  int          check_count;
  int          tb_errors = 0;
  int          cmd_count = 0;
  bit          ready;

  tb_clock_gen u_clock (
    .clk (clk),
    .rst (rst)
  );

  regfile_top uut (
    .clk          (clk),
    .rst          (rst),
    .rd_advance   (rd_advance),
    .rd0_addr     (rd0_addr),
    .rd1_addr     (rd1_addr),
    .rd0_const_en (rd0_const_en),
    .rd1_const_en (rd1_const_en),
    .rd0_const    (rd0_const),
    .rd1_const    (rd1_const),
    .ret_en       (ret_en),
    .ret_addr     (ret_addr),
    .wr0_en       (wr0_en),
    .wr0_addr     (wr0_addr),
    .wr0_data     (wr0_data),
    .wr1_en       (wr1_en),
    .wr1_addr     (wr1_addr),
    .wr1_data     (wr1_data),
    .rd0_data     (rd0_data),
    .rd1_data     (rd1_data),
    .ret_data     (ret_data),
    .init_busy    (init_busy)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .init_busy   (init_busy),
    .exp_valid   (exp_valid),
    .exp_port    (exp_port),
    .exp_data0   (exp_data0),
    .exp_data1   (exp_data1),
    .rd0_data    (rd0_data),
    .rd1_data    (rd1_data),
    .ret_data    (ret_data),
    .error_count (checker_errors),
    .check_count (check_count)
  );

  task automatic load_commands();
    int fd;
    fd = $fopen("tb/regfile_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the command file tb/regfile_input.txt");
      tb_errors++;
    end
    else
    begin
      $fclose(fd);
      $readmemh("tb/regfile_input.txt", cmds);
    end
  endtask

  task automatic wait_ready(output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (rst && cycles < RESET_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (rst)
    begin
      $display("timeout while waiting for reset to be released");
      tb_errors++;
      return;
    end
    cycles = 0;
    while (init_busy && cycles < SWEEP_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (init_busy)
    begin
      $display("timeout while waiting for init_busy to fall after the zero sweep");
      tb_errors++;
      return;
    end
    ok = 1'b1;
  endtask

  task automatic drive_idle();
    rd_advance   <= 1'b0;
    rd0_const_en <= 1'b0;
    rd1_const_en <= 1'b0;
    ret_en       <= 1'b0;
    wr0_en       <= 1'b0;
    wr1_en       <= 1'b0;
    exp_valid    <= 1'b0;
    exp_port     <= 1'b0;
  endtask

  task automatic run_command(input int base);
    logic [3:0]                     op;
    logic [regfile_pkg::ADDR_W-1:0] a0;
    logic [regfile_pkg::ADDR_W-1:0] a1;
    logic [regfile_pkg::DATA_W-1:0] d0;
    logic [regfile_pkg::DATA_W-1:0] d1;
    op = cmds[base][3:0];
    a0 = cmds[base+1][regfile_pkg::ADDR_W-1:0];
    d0 = cmds[base+2];
    a1 = cmds[base+3][regfile_pkg::ADDR_W-1:0];
    d1 = cmds[base+4];
    @(negedge clk);
    drive_idle();
    exp_data0 <= cmds[base+5];
    exp_data1 <= cmds[base+6];
    case (op)
      4'h1, 4'h2, 4'h3:
      begin
        wr0_en   <= op[0];
        wr0_addr <= a0;
        wr0_data <= d0;
        wr1_en   <= op[1];
        wr1_addr <= a1;
        wr1_data <= d1;
      end
      4'h4, 4'h5:
      begin
        // 5 is the same read with both constant bypasses set
        rd_advance   <= 1'b1;
        rd0_addr     <= a0;
        rd1_addr     <= a1;
        rd0_const_en <= (op == 4'h5);
        rd1_const_en <= (op == 4'h5);
        rd0_const    <= d0;
        rd1_const    <= d1;
        exp_valid    <= 1'b1;
      end
      4'h6:
      begin
        // new addresses are presented but must not be captured
        rd0_addr  <= a0;
        rd1_addr  <= a0;
        wr0_en    <= 1'b1;
        wr0_addr  <= a1;
        wr0_data  <= d0;
        exp_valid <= 1'b1;
      end
      4'h7:
      begin
        ret_en    <= 1'b1;
        ret_addr  <= a0;
        exp_valid <= 1'b1;
        exp_port  <= 1'b1;
      end
      default:
      begin
        $display("unknown command %h in the command file", op);
        tb_errors++;
      end
    endcase
  endtask

  initial
  begin
    drive_idle();
    rd0_addr  <= '0;
    rd1_addr  <= '0;
    rd0_const <= '0;
    rd1_const <= '0;
    ret_addr  <= '0;
    wr0_addr  <= '0;
    wr0_data  <= '0;
    wr1_addr  <= '0;
    wr1_data  <= '0;
    exp_data0 <= '0;
    exp_data1 <= '0;
    load_commands();
    wait_ready(ready);
    if (ready)
    begin
      for (int i = 0; i < MAX_CMDS; i++)
      begin
        if ($isunknown(cmds[i*FIELDS]) || cmds[i*FIELDS] == 32'hf || cmds[i*FIELDS] == '0)
        begin
          break;
        end
        run_command(i * FIELDS);
        cmd_count++;
      end
      // one idle cycle lets the checker see the last command
      @(negedge clk);
      drive_idle();
      @(negedge clk);
      if (cmd_count == 0)
      begin
        $display("no commands were read from the command file");
        tb_errors++;
      end
    end
    $display("commands %0d, checks %0d, errors %0d", cmd_count, check_count,
             checker_errors + tb_errors);
    if (checker_errors + tb_errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/regfile_input.txt ====
// columns: op addr0 data0 addr1 data1 exp0 exp1, all hex, address is {row, bank, tile}
// op 1/2/3 write port 0/1/both, 4 read, 5 constant read, 6 stall with write, 7 retire, f end
// zero sweep, every tile and both banks
4 00 0 01 0 0 0
4 02 0 03 0 0 0
4 04 0 05 0 0 0
4 06 0 07 0 0 0
4 3f 0 3a 0 0 0
7 2d 0 0 0 0 0
7 3b 0 0 0 0 0
// writes through both ports across tiles, banks and rows
1 00 11111111 00 0 0 0
2 00 0 04 22222222 0 0
3 01 33333333 05 44444444 0 0
3 3a aaaa0001 3b bbbb0002 0 0
3 2e cccc0003 1f dddd0004 0 0
4 00 0 04 0 11111111 22222222
4 04 0 00 0 22222222 11111111
4 01 0 05 0 33333333 44444444
4 3a 0 3b 0 aaaa0001 bbbb0002
4 2e 0 1f 0 cccc0003 dddd0004
4 02 0 06 0 0 0
// constant bypass
5 00 deadbeef 04 cafef00d deadbeef cafef00d
4 00 0 00 0 11111111 11111111
5 3a 0 3b 12345678 0 12345678
// stall holds 01 and 3a while writes land on them
4 01 0 3a 0 33333333 aaaa0001
6 00 55555555 01 0 55555555 aaaa0001
6 04 66666666 3a 0 55555555 66666666
4 00 0 04 0 11111111 22222222
// write collision, port 1 wins
3 15 77777777 15 88888888 0 0
4 15 0 15 0 88888888 88888888
3 0c 99999999 0c abcdef01 0 0
4 0c 0 2e 0 abcdef01 cccc0003
// retire port with rd_advance low
7 00 0 0 0 11111111 0
7 15 0 0 0 88888888 0
7 3a 0 0 0 66666666 0
7 1f 0 0 0 dddd0004 0
7 01 0 0 0 55555555 0
7 2a 0 0 0 0 0
f 0 0 0 0 0 0

// ==== regfile_top.f ====
logic/regfile_pkg.sv
logic/rf_bank_ram.sv
logic/rf_tile.sv
logic/rf_init_sweep.sv
logic/rf_read_merge.sv
logic/regfile_top.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/tb_regfile.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_regfile -f regfile_top.f -o sim_regfile \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_regfile > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "result: FAIL"; exit 1; } \
  || { echo "result: PASS"; exit 0; }
